//--- verilog/mdom_pkg.sv
// mdom shared definitions
// bus widths, register map, firmware version and the packed types
// that carry the fmc bus, register writes and discriminator words
package mdom_pkg;

  // fmc parallel bus
  localparam int FMC_ADDR_W = 12;
  localparam int FMC_DATA_W = 16;

  // discriminator samples per lclk cycle
  localparam int N_DISCR_BITS = 8;

  // scaler count and period width
  localparam int SCALER_W = 32;

  localparam logic [FMC_DATA_W-1:0] FW_VNUM = 16'h0009;

  // register map
  localparam logic [FMC_ADDR_W-1:0] ADDR_VNUM             = 12'hfff;
  // period in lclk cycles
  localparam logic [FMC_ADDR_W-1:0] ADDR_SCALER_PERIOD_HI = 12'hbba;
  localparam logic [FMC_ADDR_W-1:0] ADDR_SCALER_PERIOD_LO = 12'hbb9;
  // readback channel select
  localparam logic [FMC_ADDR_W-1:0] ADDR_SCALER_SEL       = 12'hbb8;
  // selected channel count, read only
  localparam logic [FMC_ADDR_W-1:0] ADDR_SCALER_OUT_HI    = 12'hbb7;
  localparam logic [FMC_ADDR_W-1:0] ADDR_SCALER_OUT_LO    = 12'hbb6;

  // raw fmc pins, strobes active low
  typedef struct packed {
    logic [FMC_ADDR_W-1:0] a;
    logic [FMC_DATA_W-1:0] din;
    logic                  cen_n;
    logic                  oen_n;
    logic                  wen_n;
  } fmc_pins_t;

  // one register write in the lclk domain
  typedef struct packed {
    logic                  strobe;
    logic [FMC_ADDR_W-1:0] addr;
    logic [FMC_DATA_W-1:0] data;
  } reg_wr_t;

  // bit 0 is the oldest sample
  typedef logic [N_DISCR_BITS-1:0] discr_word_t;

endpackage

//--- verilog/fmc_bridge.sv
`timescale 1ns/1ps
// fmc bridge
// brings the asynchronous fmc bus into lclk, turning a write into a
// one-cycle strobe and handing the read address and data back out
module fmc_bridge (
  input  logic                            lclk,
  input  logic                            lclk_rst,
  input  mdom_pkg::fmc_pins_t             i_fmc,
  input  logic [mdom_pkg::FMC_DATA_W-1:0] i_rd_data,
  output mdom_pkg::reg_wr_t               o_wr,
  output logic [mdom_pkg::FMC_ADDR_W-1:0] o_rd_addr,
  output logic [mdom_pkg::FMC_DATA_W-1:0] o_fmc_dout,
  output logic                            o_fmc_oe
);

  // [0] meta, [1] synced, [2] synced one cycle late
  logic [2:0] wen_sync;
  logic       wen_fall;
  logic       cen_n_1;
  // write payload, sampled every cycle
  logic [mdom_pkg::FMC_ADDR_W-1:0] a_1;
  logic [mdom_pkg::FMC_DATA_W-1:0] din_1;

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      // bus idles with strobes high
      wen_sync <= '1;
      cen_n_1  <= 1'b1;
      o_fmc_oe <= 1'b0;
      o_fmc_dout <= '0;
    end else begin
      wen_sync <= {wen_sync[1:0], i_fmc.wen_n};
      cen_n_1  <= i_fmc.cen_n;
      // drive the data pins only for a selected read
      o_fmc_oe <= ~i_fmc.oen_n & ~i_fmc.cen_n;
      // second stage of read latency
      o_fmc_dout <= i_rd_data;
    end
  end

  always_ff @(posedge lclk) begin
    a_1   <= i_fmc.a;
    din_1 <= i_fmc.din;
  end

  // wen_n high then low after sync
  assign wen_fall = wen_sync[2] & ~wen_sync[1];

  // single-cycle strobe, only while chip enable was low
  // no burst support, each write needs its own wen_n pulse
  always_comb begin
    o_wr.strobe = wen_fall & ~cen_n_1;
    o_wr.addr   = a_1;
    o_wr.data   = din_1;
  end

  // live address during a read, otherwise the registered one
  assign o_rd_addr = i_fmc.oen_n ? a_1 : i_fmc.a;

endmodule

//--- verilog/xdom_regs.sv
`timescale 1ns/1ps
// xdom register block
// holds the scaler period and readback select, and returns the
// version, those settings and the selected channel count
module xdom_regs #(
  parameter int N_CHANNELS = 24
) (
  input  logic                            lclk,
  input  logic                            lclk_rst,
  input  mdom_pkg::reg_wr_t               i_wr,
  input  logic [mdom_pkg::FMC_ADDR_W-1:0] i_rd_addr,
  input  logic [N_CHANNELS-1:0][mdom_pkg::SCALER_W-1:0] i_scaler_count,
  output logic [mdom_pkg::FMC_DATA_W-1:0] o_rd_data,
  output logic [mdom_pkg::SCALER_W-1:0]   o_scaler_period
);

  // wide enough to hold any channel number
  localparam int SEL_W = (N_CHANNELS > 1) ? $clog2(N_CHANNELS) : 1;

  logic [mdom_pkg::SCALER_W-1:0]   scaler_period;
  logic [SEL_W-1:0]                scaler_sel;
  logic [mdom_pkg::SCALER_W-1:0]   sel_count;
  logic [mdom_pkg::FMC_DATA_W-1:0] rd_mux;

  // register writes
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      scaler_period <= '0;
      scaler_sel    <= '0;
    end else if (i_wr.strobe) begin
      case (i_wr.addr)
        mdom_pkg::ADDR_SCALER_PERIOD_HI: begin
          scaler_period[31:16] <= i_wr.data;
        end
        mdom_pkg::ADDR_SCALER_PERIOD_LO: begin
          scaler_period[15:0] <= i_wr.data;
        end
        mdom_pkg::ADDR_SCALER_SEL: begin
          scaler_sel <= i_wr.data[SEL_W-1:0];
        end
        default: begin
          // read-only or unmapped, ignore
        end
      endcase
    end
  end

  // selected channel, zero past the last channel
  always_comb begin
    if (scaler_sel < N_CHANNELS) begin
      sel_count = i_scaler_count[scaler_sel];
    end else begin
      sel_count = '0;
    end
  end

  // read mux
  always_comb begin
    case (i_rd_addr)
      mdom_pkg::ADDR_VNUM:             rd_mux = mdom_pkg::FW_VNUM;
      mdom_pkg::ADDR_SCALER_PERIOD_HI: rd_mux = scaler_period[31:16];
      mdom_pkg::ADDR_SCALER_PERIOD_LO: rd_mux = scaler_period[15:0];
      mdom_pkg::ADDR_SCALER_SEL:       rd_mux = 16'(scaler_sel);
      mdom_pkg::ADDR_SCALER_OUT_HI:    rd_mux = sel_count[31:16];
      mdom_pkg::ADDR_SCALER_OUT_LO:    rd_mux = sel_count[15:0];
      default:                         rd_mux = '0;
    endcase
  end

  // first stage of read latency
  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      o_rd_data <= '0;
    end else begin
      o_rd_data <= rd_mux;
    end
  end

  assign o_scaler_period = scaler_period;

endmodule

//--- verilog/discr_scaler.sv
`timescale 1ns/1ps
// discriminator rate scaler
// counts rising edges in one channel's sample words over a
// programmable window and latches the total at each wrap
module discr_scaler (
  input  logic                          lclk,
  input  logic                          lclk_rst,
  input  mdom_pkg::discr_word_t         i_discr,
  input  logic [mdom_pkg::SCALER_W-1:0] i_period,
  output logic [mdom_pkg::SCALER_W-1:0] o_count
);

  // last sample of the previous word
  logic                                prev_msb;
  // bit j set for a 0 to 1 step into sample j
  logic [mdom_pkg::N_DISCR_BITS-1:0]   rise_bits;
  logic [3:0]                          n_rise;
  logic [mdom_pkg::SCALER_W-1:0]       win_cnt;
  logic [mdom_pkg::SCALER_W-1:0]       acc;

  assign rise_bits = i_discr & ~{i_discr[mdom_pkg::N_DISCR_BITS-2:0], prev_msb};

  // popcount of the rising edges in this word
  always_comb begin
    n_rise = '0;
    for (int j = 0; j < mdom_pkg::N_DISCR_BITS; j++) begin
      n_rise = n_rise + 4'(rise_bits[j]);
    end
  end

  always_ff @(posedge lclk) begin
    if (lclk_rst) begin
      prev_msb <= 1'b0;
      win_cnt  <= '0;
      acc      <= '0;
      o_count  <= '0;
    end else begin
      prev_msb <= i_discr[mdom_pkg::N_DISCR_BITS-1];
      if (i_period == '0) begin
        // scaler stopped, last total stays readable
        win_cnt <= '0;
        acc     <= '0;
      end else if (win_cnt >= i_period - 1'b1) begin
        // window done, include this cycle's edges
        win_cnt <= '0;
        acc     <= '0;
        o_count <= acc + 32'(n_rise);
      end else begin
        win_cnt <= win_cnt + 1'b1;
        acc     <= acc + 32'(n_rise);
      end
    end
  end

endmodule

//--- verilog/mdom_top.sv
`timescale 1ns/1ps
// mdom slow-control top level
// fmc bridge and register block plus one rate scaler per channel
module mdom_top #(
  parameter int N_CHANNELS = 24
) (
  input  logic                                     lclk,
  input  logic                                     lclk_rst,
  input  mdom_pkg::fmc_pins_t                      i_fmc,
  input  mdom_pkg::discr_word_t [N_CHANNELS-1:0]   i_discr,
  output logic [mdom_pkg::FMC_DATA_W-1:0]          o_fmc_dout,
  output logic                                     o_fmc_oe
);

  // bridge to registers
  mdom_pkg::reg_wr_t               fmc_wr;
  logic [mdom_pkg::FMC_ADDR_W-1:0] rd_addr;
  logic [mdom_pkg::FMC_DATA_W-1:0] rd_data;

  // registers to scalers and back
  logic [mdom_pkg::SCALER_W-1:0]                  scaler_period;
  logic [N_CHANNELS-1:0][mdom_pkg::SCALER_W-1:0]  scaler_count;

  fmc_bridge fmc_bridge_i (
    .lclk       (lclk),
    .lclk_rst   (lclk_rst),
    .i_fmc      (i_fmc),
    .i_rd_data  (rd_data),
    .o_wr       (fmc_wr),
    .o_rd_addr  (rd_addr),
    .o_fmc_dout (o_fmc_dout),
    .o_fmc_oe   (o_fmc_oe)
  );

  xdom_regs #(.N_CHANNELS(N_CHANNELS)) xdom_regs_i (
    .lclk            (lclk),
    .lclk_rst        (lclk_rst),
    .i_wr            (fmc_wr),
    .i_rd_addr       (rd_addr),
    .i_scaler_count  (scaler_count),
    .o_rd_data       (rd_data),
    .o_scaler_period (scaler_period)
  );

  // one scaler per discriminator channel, shared period
  for (genvar i = 0; i < N_CHANNELS; i++) begin : scaler_gen
    discr_scaler discr_scaler_i (
      .lclk     (lclk),
      .lclk_rst (lclk_rst),
      .i_discr  (i_discr[i]),
      .i_period (scaler_period),
      .o_count  (scaler_count[i])
    );
  end

endmodule

//--- verif/mdom_top_properties.sv
`timescale 1ns/1ps
// mdom_top bus properties
// write strobe width and fmc output enable behavior, bound to the top
module mdom_top_properties (
  input logic                lclk,
  input logic                lclk_rst,
  input mdom_pkg::fmc_pins_t i_fmc,
  input mdom_pkg::reg_wr_t   i_wr,
  input logic                i_fmc_oe
);

  // one wen_n pulse gives one strobe cycle
  a_strobe_single: assert property (
    @(posedge lclk) disable iff (lclk_rst)
    i_wr.strobe |=> !i_wr.strobe
  ) else $error("write strobe high on two consecutive cycles");

  // data pins released once oen_n is back high
  a_oe_idle: assert property (
    @(posedge lclk) disable iff (lclk_rst)
    (i_fmc.oen_n && $past(i_fmc.oen_n)) |-> !i_fmc_oe
  ) else $error("fmc output enable high while oen_n is high");

  // reset state of the bus outputs
  a_reset_quiet: assert property (
    @(posedge lclk)
    lclk_rst |=> (!i_fmc_oe && !i_wr.strobe)
  ) else $error("output enable or write strobe high after reset");

endmodule

bind mdom_top mdom_top_properties mdom_top_properties_i (
  .lclk     (lclk),
  .lclk_rst (lclk_rst),
  .i_fmc    (i_fmc),
  .i_wr     (fmc_wr),
  .i_fmc_oe (o_fmc_oe)
);

//--- verif/mdom_top_tb.sv
`timescale 1ns/1ps
// mdom_top testbench
// directed tests over the fmc bus for the version and period registers,
// scaler readback, idle channels and a write with chip enable high
module mdom_top_tb;

  localparam int N_CHANNELS      = 24;
  localparam int MAX_PERIOD      = 100;
  localparam int N_TESTS         = 5;
  localparam int WATCHDOG_CYCLES = N_TESTS * 4 * MAX_PERIOD + 2000;
  // outside the register map
  localparam logic [mdom_pkg::FMC_ADDR_W-1:0] ADDR_UNMAPPED = 12'h123;

  logic                                   lclk = 1'b0;
  logic                                   lclk_rst;
  mdom_pkg::fmc_pins_t                    fmc;
  mdom_pkg::discr_word_t [N_CHANNELS-1:0] discr;
  logic [mdom_pkg::FMC_DATA_W-1:0]        fmc_dout;
  logic                                   fmc_oe;

  integer seed = 32'hd115;
  int word_errs  = 0;
  int count_errs = 0;
  int bus_errs   = 0;
  // scaler period left running by the count test
  logic [mdom_pkg::SCALER_W-1:0] period;

  mdom_top #(.N_CHANNELS(N_CHANNELS)) mdom_top_i (
    .lclk       (lclk),
    .lclk_rst   (lclk_rst),
    .i_fmc      (fmc),
    .i_discr    (discr),
    .o_fmc_dout (fmc_dout),
    .o_fmc_oe   (fmc_oe)
  );

  always #5 lclk = ~lclk;

  task automatic check_word(input string name, input logic [mdom_pkg::FMC_DATA_W-1:0] exp,
                            input logic [mdom_pkg::FMC_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, got %h", name, exp, act);
      word_errs++;
    end
  endtask

  task automatic check_count(input string name, input logic [mdom_pkg::SCALER_W-1:0] exp,
                             input logic [mdom_pkg::SCALER_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s: expected %h, got %h", name, exp, act);
      count_errs++;
    end
  endtask

  // wen_n low for 4 cycles while the strobe lands about 3 cycles in
  task automatic fmc_write(input logic [mdom_pkg::FMC_ADDR_W-1:0] addr,
                           input logic [mdom_pkg::FMC_DATA_W-1:0] data, input logic cen_n);
    @(posedge lclk);
    fmc.a     <= addr;
    fmc.din   <= data;
    fmc.cen_n <= cen_n;
    fmc.wen_n <= 1'b0;
    repeat (4) @(posedge lclk);
    fmc.wen_n <= 1'b1;
    fmc.cen_n <= 1'b1;
    repeat (2) @(posedge lclk);
  endtask

  // sampled mid-cycle after four cycles to clear the 2-cycle read latency
  task automatic fmc_read(input logic [mdom_pkg::FMC_ADDR_W-1:0] addr,
                          output logic [mdom_pkg::FMC_DATA_W-1:0] data);
    @(posedge lclk);
    fmc.a     <= addr;
    fmc.cen_n <= 1'b0;
    fmc.oen_n <= 1'b0;
    repeat (4) @(posedge lclk);
    @(negedge lclk);
    if (fmc_oe !== 1'b1) begin
      $display("read of address %h did not assert the output enable", addr);
      bus_errs++;
    end
    data = fmc_dout;
    @(posedge lclk);
    fmc.cen_n <= 1'b1;
    fmc.oen_n <= 1'b1;
  endtask

  task automatic read_count(input int ch, output logic [mdom_pkg::SCALER_W-1:0] cnt);
    logic [mdom_pkg::FMC_DATA_W-1:0] hi;
    logic [mdom_pkg::FMC_DATA_W-1:0] lo;
    fmc_write(mdom_pkg::ADDR_SCALER_SEL, 16'(ch), 1'b0);
    fmc_read(mdom_pkg::ADDR_SCALER_OUT_HI, hi);
    fmc_read(mdom_pkg::ADDR_SCALER_OUT_LO, lo);
    cnt = {hi, lo};
  endtask

  task automatic reset_defaults();
    logic [mdom_pkg::FMC_DATA_W-1:0] rd;
    fmc_read(mdom_pkg::ADDR_VNUM, rd);
    check_word("vnum", mdom_pkg::FW_VNUM, rd);
    fmc_read(mdom_pkg::ADDR_SCALER_PERIOD_HI, rd);
    check_word("scaler_period_hi", 16'h0000, rd);
    fmc_read(mdom_pkg::ADDR_SCALER_PERIOD_LO, rd);
    check_word("scaler_period_lo", 16'h0000, rd);
    fmc_read(ADDR_UNMAPPED, rd);
    check_word("unmapped", 16'h0000, rd);
  endtask

  task automatic register_readback();
    logic [mdom_pkg::FMC_DATA_W-1:0] hi;
    logic [mdom_pkg::FMC_DATA_W-1:0] lo;
    logic [mdom_pkg::FMC_DATA_W-1:0] sel;
    logic [mdom_pkg::FMC_DATA_W-1:0] rd;
    hi  = 16'($random(seed));
    lo  = 16'($random(seed));
    sel = 16'($unsigned($random(seed)) % N_CHANNELS);
    fmc_write(mdom_pkg::ADDR_SCALER_PERIOD_HI, hi, 1'b0);
    fmc_write(mdom_pkg::ADDR_SCALER_PERIOD_LO, lo, 1'b0);
    fmc_write(mdom_pkg::ADDR_SCALER_SEL, sel, 1'b0);
    fmc_read(mdom_pkg::ADDR_SCALER_PERIOD_HI, rd);
    check_word("scaler_period_hi", hi, rd);
    fmc_read(mdom_pkg::ADDR_SCALER_PERIOD_LO, rd);
    check_word("scaler_period_lo", lo, rd);
    fmc_read(mdom_pkg::ADDR_SCALER_SEL, rd);
    check_word("scaler_sel", sel, rd);
  endtask

  task automatic edge_count_readback();
    int                            ch;
    int                            k;
    mdom_pkg::discr_word_t         word;
    logic [mdom_pkg::SCALER_W-1:0] cnt;
    ch     = $unsigned($random(seed)) % N_CHANNELS;
    k      = 1 + $unsigned($random(seed)) % 4;
    period = 32'(20 + $unsigned($random(seed)) % 64);
    // pulses on even samples so bit 0 after a low bit 7 gives the wrap edge
    word = '0;
    for (int i = 0; i < k; i++) begin
      word[2 * i] = 1'b1;
    end
    @(posedge lclk);
    discr[ch] <= word;
    fmc_write(mdom_pkg::ADDR_SCALER_PERIOD_HI, period[31:16], 1'b0);
    fmc_write(mdom_pkg::ADDR_SCALER_PERIOD_LO, period[15:0], 1'b0);
    repeat (3 * period) @(posedge lclk);
    read_count(ch, cnt);
    check_count("scaler_out", 32'(k) * period, cnt);
  endtask

  task automatic idle_channel_counts();
    int                            ch_ones;
    int                            ch_zeros;
    logic [mdom_pkg::SCALER_W-1:0] cnt;
    ch_ones  = $unsigned($random(seed)) % N_CHANNELS;
    ch_zeros = (ch_ones + 1 + $unsigned($random(seed)) % (N_CHANNELS - 1)) % N_CHANNELS;
    @(posedge lclk);
    // other channels see one edge per cycle so a wrong select reads nonzero
    discr           <= {N_CHANNELS{8'h01}};
    discr[ch_ones]  <= 8'hff;
    discr[ch_zeros] <= 8'h00;
    repeat (3 * period) @(posedge lclk);
    read_count(ch_ones, cnt);
    check_count("scaler_out_ones", 32'h0, cnt);
    read_count(ch_zeros, cnt);
    check_count("scaler_out_zeros", 32'h0, cnt);
    // channel 30 does not exist
    read_count(30, cnt);
    check_count("scaler_out_sel30", 32'h0, cnt);
  endtask

  task automatic deselected_write();
    logic [mdom_pkg::FMC_DATA_W-1:0] rd;
    fmc_write(mdom_pkg::ADDR_SCALER_PERIOD_LO, ~period[15:0], 1'b1);
    fmc_write(mdom_pkg::ADDR_SCALER_PERIOD_HI, 16'hffff, 1'b1);
    fmc_read(mdom_pkg::ADDR_SCALER_PERIOD_LO, rd);
    check_word("scaler_period_lo", period[15:0], rd);
    fmc_read(mdom_pkg::ADDR_SCALER_PERIOD_HI, rd);
    check_word("scaler_period_hi", period[31:16], rd);
  endtask

  // bounds the run at four maximum periods per test plus bus traffic
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge lclk);
    $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("*** TEST FAILED ***");
    $finish;
  end

  initial begin
    lclk_rst <= 1'b1;
    fmc      <= '{a: '0, din: '0, cen_n: 1'b1, oen_n: 1'b1, wen_n: 1'b1};
    discr    <= '0;
    period   = '0;
    repeat (5) @(posedge lclk);
    lclk_rst <= 1'b0;
    @(posedge lclk);
    reset_defaults();
    register_readback();
    edge_count_readback();
    idle_channel_counts();
    deselected_write();
    $display("errors: %0d word, %0d count, %0d bus", word_errs, count_errs, bus_errs);
    if (word_errs + count_errs + bus_errs == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- filelist.f
verilog/mdom_pkg.sv
verilog/fmc_bridge.sv
verilog/xdom_regs.sv
verilog/discr_scaler.sv
verilog/mdom_top.sv
verif/mdom_top_properties.sv
verif/mdom_top_tb.sv

//--- run.sh
#!/bin/sh
# build the mdom_top testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module mdom_top_tb \
  -f filelist.f -o mdom_top_sim \
  && ./obj_dir/mdom_top_sim | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
  && echo "simulation ok" \
  || { echo "simulation failed"; exit 1; }
